/* src/fetch_pkg.sv */
// Fetch stage shared definitions: word types, opcode codes, decode classes and timing constants
`default_nettype none

package fetch_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and word types
   ////////////////////////////////////////////////////////////

   localparam int WORD_W = 16;
   localparam int REG_W  = 3;
   localparam int OP_W   = 5;

   // Instruction or byte address
   typedef logic [WORD_W-1:0] word_t;
   // One of eight registers
   typedef logic [REG_W-1:0]  reg_idx_t;
   // Top five bits of an instruction
   typedef logic [OP_W-1:0]   opcode_t;

   ////////////////////////////////////////////////////////////
   // Opcodes and decode classes
   ////////////////////////////////////////////////////////////

   localparam opcode_t OP_HALT = 5'b00000;
   localparam opcode_t OP_NOP  = 5'b00001;

   // Bubble word, NOP opcode with every other field zero (0x0800)
   localparam word_t NOP_WORD = {OP_NOP, {(WORD_W-OP_W){1'b0}}};

   // Jumps and branches share this prefix
   localparam logic [2:0] JUMP_CLASS  = 3'b001;
   // Register-register ALU group, rd in bits 4:2
   localparam logic [3:0] CLS_RR      = 4'b1101;
   // Compares, also rd in bits 4:2
   localparam logic [2:0] CLS_CMP     = 3'b111;
   // Immediate ALU and immediate shift groups, rd in bits 7:5
   localparam logic [2:0] CLS_IMM_ALU = 3'b010;
   localparam logic [2:0] CLS_IMM_SHF = 3'b101;

   // Memory and load-immediate opcodes
   localparam opcode_t OP_ST   = 5'b10000;
   localparam opcode_t OP_LD   = 5'b10001;
   localparam opcode_t OP_SLBI = 5'b10010;
   localparam opcode_t OP_STU  = 5'b10011;
   localparam opcode_t OP_LBI  = 5'b11000;
   // Bit reverse, single source but writes rd in 4:2
   localparam opcode_t OP_BTR  = 5'b11001;

   ////////////////////////////////////////////////////////////
   // Fetch timing
   ////////////////////////////////////////////////////////////

   // Bubbles after a jump-class word
   localparam int    JUMP_SHADOW = 3;
   // Cycles from an issued HALT to the dump strobe
   localparam int    HALT_DELAY  = 4;
   // Byte step between sequential instructions
   localparam word_t PC_STEP     = 16'd2;

endpackage

`default_nettype wire

/* src/fetch_pc.sv */
// Program counter register with sequential incrementer and redirect select
`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
   input  logic             clk,
   input  logic             rst,
   // Freeze request from fetch control
   input  logic             hold,
   // Redirect strobe from a later stage
   input  logic             squash,
   input  logic             pc_src,
   input  fetch_pkg::word_t jump_pc,
   output fetch_pkg::word_t pc,
   // pc plus one instruction, also sent down the pipe
   output fetch_pkg::word_t pc_next_seq
);
   import fetch_pkg::*;

   word_t pc_new;
   logic  pc_load;

   ////////////////////////////////////////////////////////////
   // Next address
   ////////////////////////////////////////////////////////////

   assign pc_next_seq = pc + PC_STEP;

   // Redirect target wins over the sequential address
   assign pc_new = pc_src ? jump_pc : pc_next_seq;

   // Squash must land even while fetch is frozen
   assign pc_load = ~hold | squash;

   ////////////////////////////////////////////////////////////
   // PC register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (pc_load) begin
         pc <= pc_new;
      end
   end

endmodule

`default_nettype wire

/* src/imem_stall.sv */
// Word-addressed instruction memory with programmable wait states, alignment flag and load port
`timescale 1ns/1ps
`default_nettype none

module imem_stall #(
   parameter int IMEM_WORDS   = 256,
   parameter int IMEM_LATENCY = 1
) (
   input  logic             clk,
   input  logic             rst,
   // Read side, byte address from the PC
   input  fetch_pkg::word_t addr,
   output fetch_pkg::word_t instr,
   output logic             done,
   output logic             mem_err,
   // Program load port
   input  logic             load_we,
   input  fetch_pkg::word_t load_addr,
   input  fetch_pkg::word_t load_data
);
   import fetch_pkg::*;

   localparam int IDX_W = $clog2(IMEM_WORDS);
   // Wide enough to hold IMEM_LATENCY-1, never zero bits
   localparam int CNT_W = $clog2(IMEM_LATENCY + 1);
   localparam logic [CNT_W-1:0] WAIT_MAX = CNT_W'(IMEM_LATENCY - 1);

   word_t            mem [IMEM_WORDS];
   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;
   word_t            addr_q;
   logic             addr_moved;
   logic [CNT_W-1:0] wait_cnt;
   logic [CNT_W-1:0] stable;

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // Byte addresses, so bit 0 never selects a word
   assign rd_idx = addr[IDX_W:1];
   assign wr_idx = load_addr[IDX_W:1];

   // Asynchronous read
   assign instr = mem[rd_idx];

   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[wr_idx] <= load_data;
      end
   end

   // Odd address is an alignment fault
   assign mem_err = addr[0];

   ////////////////////////////////////////////////////////////
   // Wait-state counter
   ////////////////////////////////////////////////////////////

   // New address restarts the wait
   assign addr_moved = (addr != addr_q);

   // Cycles the current address has already been held
   assign stable = addr_moved ? '0 : wait_cnt;

   // Latency 1 gives WAIT_MAX of zero, so done stays high
   assign done = (stable >= WAIT_MAX);

   always_ff @(posedge clk) begin
      if (rst) begin
         addr_q   <= '0;
         wait_cnt <= '0;
      end else begin
         addr_q <= addr;
         // Saturate once the word is ready
         if (stable < WAIT_MAX) begin
            wait_cnt <= stable + 1'b1;
         end else begin
            wait_cnt <= stable;
         end
      end
   end

endmodule

`default_nettype wire

/* src/inst_decode.sv */
// Register field decode: sources of the fetched word and destination of the word in execute
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
   // Word just read from memory
   input  fetch_pkg::word_t    instr,
   // Word currently in execute
   input  fetch_pkg::word_t    instr_in_x,
   output fetch_pkg::reg_idx_t rs,
   output fetch_pkg::reg_idx_t rt,
   output logic                rs_v,
   output logic                rt_v,
   output fetch_pkg::reg_idx_t dst_x,
   output logic                dst_x_v
);
   import fetch_pkg::*;

   opcode_t op;
   opcode_t op_x;

   assign op   = instr[15:11];
   assign op_x = instr_in_x[15:11];

   ////////////////////////////////////////////////////////////
   // Source fields of the fetched word
   ////////////////////////////////////////////////////////////

   assign rs = instr[10:8];
   assign rt = instr[7:5];

   // No rs for HALT/NOP group or for immediate jumps (J, JAL)
   assign rs_v = (op[4:2] != 3'b000) && !((op[4:2] == JUMP_CLASS) && op[0]);

   // rt read by stores, compares and register-register ops
   assign rt_v = (op[4:1] == CLS_RR) || (op[4:2] == CLS_CMP) ||
                 (op == OP_ST) || (op == OP_STU);

   ////////////////////////////////////////////////////////////
   // Destination of the word in execute
   ////////////////////////////////////////////////////////////

   always_comb begin
      dst_x   = '0;
      dst_x_v = 1'b0;
      // Three-register forms
      if ((op_x[4:1] == CLS_RR) || (op_x[4:2] == CLS_CMP) || (op_x == OP_BTR)) begin
         dst_x   = instr_in_x[4:2];
         dst_x_v = 1'b1;
      // Immediate forms, rd sits where rt would be
      end else if ((op_x[4:2] == CLS_IMM_ALU) || (op_x[4:2] == CLS_IMM_SHF) ||
                   (op_x == OP_LD)) begin
         dst_x   = instr_in_x[7:5];
         dst_x_v = 1'b1;
      // Load-immediate writes the rs field
      end else if ((op_x == OP_LBI) || (op_x == OP_SLBI)) begin
         dst_x   = instr_in_x[10:8];
         dst_x_v = 1'b1;
      end
      // Stores, jumps, HALT and NOP write nothing
   end

endmodule

`default_nettype wire

/* src/raw_detector.sv */
// Read-after-write check of two source registers against one pending destination
`timescale 1ns/1ps
`default_nettype none

module raw_detector (
   // Sources of the word being fetched
   input  fetch_pkg::reg_idx_t src1,
   input  fetch_pkg::reg_idx_t src2,
   input  logic                src1_v,
   input  logic                src2_v,
   // Destination still in flight
   input  fetch_pkg::reg_idx_t dst,
   input  logic                dst_v,
   output logic                raw
);

   logic hit1;
   logic hit2;

   ////////////////////////////////////////////////////////////
   // Per-source compare
   ////////////////////////////////////////////////////////////

   // A source only counts when the opcode actually reads it
   assign hit1 = src1_v && (src1 == dst);
   assign hit2 = src2_v && (src2 == dst);

   // Nothing to wait for if the older word writes no register
   assign raw = dst_v && (hit1 || hit2);

endmodule

`default_nettype wire

/* src/fetch_ctrl.sv */
// Fetch control: bubble and hold decisions, jump shadow, halt countdown and dump strobe
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
   input  logic             clk,
   input  logic             rst,
   // Word leaving fetch this cycle, already NOP when not taken
   input  fetch_pkg::word_t instr_sel,
   input  logic             done,
   input  logic             raw_d,
   input  logic             raw_x,
   input  logic             squash,
   input  logic             mem_stall,
   input  logic             mem_err,
   output logic             bubble,
   output logic             hold_pc,
   output logic             dump
);
   import fetch_pkg::*;

   opcode_t                op_sel;
   logic                   take;
   logic                   jump_start;
   logic                   halt_start;
   // Bit k set means the jump left fetch k+1 cycles ago
   logic [JUMP_SHADOW-1:0] jump_sr;
   // Bit k set means the HALT left fetch k+1 cycles ago
   logic [HALT_DELAY-1:0]  halt_sr;
   // Sticky stop after HALT or alignment fault
   logic                   halted;

   assign op_sel = instr_sel[15:11];

   ////////////////////////////////////////////////////////////
   // Bubble and hold
   ////////////////////////////////////////////////////////////

   // Hazards, jump shadow, memory wait, or fetch stopped
   assign bubble = raw_d | raw_x | (|jump_sr) | ~done | halted;

   // Real word goes down the pipe this cycle
   assign take = ~(bubble | squash);

   // PC moves again in the last shadow cycle
   assign hold_pc = (bubble & ~jump_sr[JUMP_SHADOW-1]) | halted | mem_stall;

   ////////////////////////////////////////////////////////////
   // Events seen on the outgoing word
   ////////////////////////////////////////////////////////////

   // NOP never matches the jump prefix
   assign jump_start = (op_sel[4:2] == JUMP_CLASS);

   // Odd address stops fetch the same way a HALT does
   assign halt_start = take & ((op_sel == OP_HALT) | mem_err);

   ////////////////////////////////////////////////////////////
   // Shift registers and stop flag
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         jump_sr <= '0;
         halt_sr <= '0;
         halted  <= 1'b0;
      end else if (!mem_stall) begin
         if (squash) begin
            // Younger words are gone, so is anything they started
            jump_sr <= '0;
            halt_sr <= '0;
            halted  <= 1'b0;
         end else begin
            jump_sr <= {jump_sr[JUMP_SHADOW-2:0], jump_start};
            halt_sr <= {halt_sr[HALT_DELAY-2:0], halt_start};
            halted  <= halted | halt_start;
         end
      end
   end

   // Fires the cycle after the countdown bit reaches the end
   // Held back during a stall, the bit waits in place
   always_ff @(posedge clk) begin
      if (rst) begin
         dump <= 1'b0;
      end else begin
         dump <= halt_sr[HALT_DELAY-1] & ~mem_stall & ~squash;
      end
   end

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
// Instruction fetch stage: PC, stalling instruction memory, RAW checks and fetch-to-decode registers
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
   parameter int IMEM_WORDS   = 256,
   parameter int IMEM_LATENCY = 1
) (
   input  logic                clk,
   input  logic                rst,
   // Redirect from a later stage
   input  logic                pc_src,
   input  fetch_pkg::word_t    jump_pc,
   input  logic                squash,
   input  logic                mem_stall,
   // Destination of the word in decode
   input  fetch_pkg::reg_idx_t dst1,
   input  logic                valid1,
   // Word in execute
   input  fetch_pkg::word_t    instr_in_x,
   // Program load
   input  logic                load_we,
   input  fetch_pkg::word_t    load_addr,
   input  fetch_pkg::word_t    load_data,
   // Toward decode
   output fetch_pkg::word_t    instr_out,
   output fetch_pkg::word_t    incr_pc,
   output logic                dump,
   output logic                unaligned_error_out
);
   import fetch_pkg::*;

   word_t    pc;
   word_t    pc_next_seq;
   word_t    instr;
   word_t    instr_sel;
   logic     done;
   logic     mem_err;
   logic     bubble;
   logic     hold_pc;
   logic     take;
   reg_idx_t rs;
   reg_idx_t rt;
   logic     rs_v;
   logic     rt_v;
   reg_idx_t dst_x;
   logic     dst_x_v;
   logic     raw_d;
   logic     raw_x;

   ////////////////////////////////////////////////////////////
   // PC and memory
   ////////////////////////////////////////////////////////////

   fetch_pc u_pc (
      .clk         (clk),
      .rst         (rst),
      .hold        (hold_pc),
      .squash      (squash),
      .pc_src      (pc_src),
      .jump_pc     (jump_pc),
      .pc          (pc),
      .pc_next_seq (pc_next_seq)
   );

   imem_stall #(
      .IMEM_WORDS   (IMEM_WORDS),
      .IMEM_LATENCY (IMEM_LATENCY)
   ) u_imem (
      .clk       (clk),
      .rst       (rst),
      .addr      (pc),
      .instr     (instr),
      .done      (done),
      .mem_err   (mem_err),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data)
   );

   ////////////////////////////////////////////////////////////
   // Hazard detection
   ////////////////////////////////////////////////////////////

   inst_decode u_dec (
      .instr      (instr),
      .instr_in_x (instr_in_x),
      .rs         (rs),
      .rt         (rt),
      .rs_v       (rs_v),
      .rt_v       (rt_v),
      .dst_x      (dst_x),
      .dst_x_v    (dst_x_v)
   );

   // Against the word one stage ahead, in decode
   raw_detector u_raw_d (
      .src1   (rs),
      .src2   (rt),
      .src1_v (rs_v),
      .src2_v (rt_v),
      .dst    (dst1),
      .dst_v  (valid1),
      .raw    (raw_d)
   );

   // Against the word two stages ahead, in execute
   raw_detector u_raw_x (
      .src1   (rs),
      .src2   (rt),
      .src1_v (rs_v),
      .src2_v (rt_v),
      .dst    (dst_x),
      .dst_v  (dst_x_v),
      .raw    (raw_x)
   );

   ////////////////////////////////////////////////////////////
   // Control and word select
   ////////////////////////////////////////////////////////////

   fetch_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .instr_sel (instr_sel),
      .done      (done),
      .raw_d     (raw_d),
      .raw_x     (raw_x),
      .squash    (squash),
      .mem_stall (mem_stall),
      .mem_err   (mem_err),
      .bubble    (bubble),
      .hold_pc   (hold_pc),
      .dump      (dump)
   );

   assign take      = ~(bubble | squash);
   assign instr_sel = take ? instr : NOP_WORD;

   ////////////////////////////////////////////////////////////
   // Fetch-to-decode registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         instr_out           <= NOP_WORD;
         incr_pc             <= '0;
         unaligned_error_out <= 1'b0;
      end else if (!mem_stall) begin
         instr_out           <= instr_sel;
         incr_pc             <= pc_next_seq;
         // Fault travels only with a word that really issued
         unaligned_error_out <= take & mem_err;
      end
   end

endmodule

`default_nettype wire

/* tb/fetch_stage_tb.sv */
// Directed testbench for the fetch stage covering order, hazards, jumps, halt, stalls and alignment
`timescale 1ns/1ps
`default_nettype none

module fetch_stage_tb;
   import fetch_pkg::*;

   localparam int    CLK_PERIOD      = 100;
   localparam int    RESET_CYCLES    = 4;
   localparam int    NUM_TESTS       = 6;
   localparam int    CYCLES_PER_TEST = 200;
   // Longest gap allowed between two real words on instr_out
   localparam int    WAIT_LIMIT      = 40;
   localparam int    STALL_WORDS     = 8;
   localparam word_t HALT_WORD       = {OP_HALT, 11'd0};
   localparam word_t JUMP_TARGET     = 16'h0040;

   logic     clk;
   logic     rst;
   logic     pc_src;
   word_t    jump_pc;
   logic     squash;
   logic     mem_stall;
   reg_idx_t dst1;
   logic     valid1;
   word_t    instr_in_x;
   logic     load_we;
   word_t    load_addr;
   word_t    load_data;
   word_t    instr_out;
   word_t    incr_pc;
   logic     dump;
   logic     unaligned_error_out;

   // Byte address and word of each entry in the running test's program
   word_t    prog_addr [$];
   word_t    prog_data [$];

   fetch_stage #(
      .IMEM_WORDS   (256),
      .IMEM_LATENCY (2)
   ) dut0 (
      .clk                 (clk),
      .rst                 (rst),
      .pc_src              (pc_src),
      .jump_pc             (jump_pc),
      .squash              (squash),
      .mem_stall           (mem_stall),
      .dst1                (dst1),
      .valid1              (valid1),
      .instr_in_x          (instr_in_x),
      .load_we             (load_we),
      .load_addr           (load_addr),
      .load_data           (load_data),
      .instr_out           (instr_out),
      .incr_pc             (incr_pc),
      .dump                (dump),
      .unaligned_error_out (unaligned_error_out)
   );

   ////////////////////////////////////////////////////////////
   // Clock and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Watchdog expired, tests ran past %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
      report_failure();
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic report_failure();
      $display("TB FAILED");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic compare_value(input string name, input word_t got, input word_t exp);
      assert (got === exp) else begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         report_failure();
      end
   endtask

   // Random opcode from 01000 to 11111 that is never HALT, NOP or jump class
   function automatic word_t filler_word();
      opcode_t op;
      op = opcode_t'(8 + ($urandom % 24));
      return {op, 11'($urandom)};
   endfunction

   task automatic clear_program();
      prog_addr.delete();
      prog_data.delete();
   endtask

   task automatic place_word(input word_t addr, input word_t data);
      prog_addr.push_back(addr);
      prog_data.push_back(data);
   endtask

   // Program goes in through the load port while reset is high
   task automatic reset_and_load();
      @(posedge clk);
      rst        <= 1'b1;
      squash     <= 1'b0;
      pc_src     <= 1'b0;
      jump_pc    <= '0;
      mem_stall  <= 1'b0;
      valid1     <= 1'b0;
      dst1       <= '0;
      instr_in_x <= NOP_WORD;
      foreach (prog_addr[i]) begin
         load_we   <= 1'b1;
         load_addr <= prog_addr[i];
         load_data <= prog_data[i];
         @(posedge clk);
      end
      load_we <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      compare_value("instr_out", instr_out, NOP_WORD);
      compare_value("incr_pc", incr_pc, 16'h0000);
      compare_value("dump", word_t'(dump), 16'h0000);
      compare_value("unaligned_error_out", word_t'(unaligned_error_out), 16'h0000);
   endtask

   // Skip bubbles and match the next real word and its address plus one step
   task automatic expect_word(input word_t data, input word_t addr);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while ((instr_out == NOP_WORD) && (n < WAIT_LIMIT));
      assert (instr_out != NOP_WORD) else begin
         $display("No instruction reached instr_out within %0d cycles", WAIT_LIMIT);
         report_failure();
      end
      compare_value("instr_out", instr_out, data);
      compare_value("incr_pc", incr_pc, word_t'(addr + PC_STEP));
   endtask

   task automatic nop_cycles(input int count);
      repeat (count) begin
         @(negedge clk);
         compare_value("instr_out", instr_out, NOP_WORD);
      end
   endtask

   // One-cycle squash with the redirect target
   task automatic send_redirect(input word_t target);
      @(posedge clk);
      squash  <= 1'b1;
      pc_src  <= 1'b1;
      jump_pc <= target;
      @(posedge clk);
      squash  <= 1'b0;
      pc_src  <= 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic straight_line_fetch();
      int i;
      clear_program();
      for (i = 0; i < 6; i++) begin
         place_word(word_t'(2 * i), filler_word());
      end
      place_word(16'd12, HALT_WORD);
      reset_and_load();
      for (i = 0; i < 6; i++) begin
         expect_word(prog_data[i], prog_addr[i]);
         compare_value("unaligned_error_out", word_t'(unaligned_error_out), 16'h0000);
         compare_value("dump", word_t'(dump), 16'h0000);
      end
      expect_word(HALT_WORD, 16'd12);
   endtask

   task automatic raw_hazard_stall();
      reg_idx_t r;
      word_t    x_word;
      r = reg_idx_t'($urandom % 8);
      clear_program();
      // First word reads another register and issues under the hazard
      place_word(16'd0, {5'b01000, r + 3'd1, 8'($urandom)});
      place_word(16'd2, {5'b01000, r, 8'($urandom)});
      place_word(16'd4, filler_word());
      place_word(16'd6, HALT_WORD);
      // Immediate ALU word in execute with rd in bits 7:5
      x_word = {5'b01000, 3'b000, r, 5'b00000};
      reset_and_load();
      @(posedge clk);
      valid1 <= 1'b1;
      dst1   <= r;
      expect_word(prog_data[0], prog_addr[0]);
      nop_cycles(8);
      // Hand the hazard over from decode to execute without a gap
      @(posedge clk);
      valid1     <= 1'b0;
      instr_in_x <= x_word;
      nop_cycles(8);
      @(posedge clk);
      instr_in_x <= NOP_WORD;
      expect_word(prog_data[1], prog_addr[1]);
      expect_word(prog_data[2], prog_addr[2]);
   endtask

   task automatic jump_and_redirect();
      clear_program();
      place_word(16'h0000, filler_word());
      // Opcode 00100, jump class with a register source
      place_word(16'h0002, {5'b00100, 11'($urandom)});
      place_word(16'h0004, filler_word());
      place_word(16'h0006, filler_word());
      place_word(16'h0008, HALT_WORD);
      place_word(JUMP_TARGET, filler_word());
      place_word(16'h0042, filler_word());
      place_word(16'h0044, HALT_WORD);
      reset_and_load();
      expect_word(prog_data[0], prog_addr[0]);
      expect_word(prog_data[1], prog_addr[1]);
      nop_cycles(JUMP_SHADOW);
      send_redirect(JUMP_TARGET);
      expect_word(prog_data[5], prog_addr[5]);
      expect_word(prog_data[6], prog_addr[6]);
   endtask

   task automatic halt_and_dump();
      int k;
      clear_program();
      place_word(16'd0, filler_word());
      place_word(16'd2, filler_word());
      place_word(16'd4, HALT_WORD);
      place_word(16'd6, filler_word());
      place_word(16'd8, filler_word());
      reset_and_load();
      expect_word(prog_data[0], prog_addr[0]);
      expect_word(prog_data[1], prog_addr[1]);
      expect_word(HALT_WORD, 16'd4);
      // Exactly one dump cycle and nothing fetched past the HALT
      for (k = 1; k <= HALT_DELAY + 6; k++) begin
         @(negedge clk);
         compare_value("dump", word_t'(dump), word_t'(k == HALT_DELAY));
         compare_value("instr_out", instr_out, NOP_WORD);
      end
   endtask

   task automatic mem_stall_hold();
      int    idx;
      int    n;
      int    stall_cnt;
      logic  stalled;
      word_t prev_instr;
      word_t prev_incr;
      clear_program();
      for (idx = 0; idx < STALL_WORDS; idx++) begin
         place_word(word_t'(2 * idx), filler_word());
      end
      place_word(word_t'(2 * STALL_WORDS), HALT_WORD);
      reset_and_load();
      idx        = 0;
      n          = 0;
      stall_cnt  = 0;
      prev_instr = instr_out;
      prev_incr  = incr_pc;
      while ((idx < STALL_WORDS) && (n < CYCLES_PER_TEST - 40)) begin
         @(posedge clk);
         // Level the registers saw on this edge
         stalled = mem_stall;
         mem_stall <= (($urandom % 3) == 0);
         @(negedge clk);
         n++;
         if (stalled) begin
            compare_value("instr_out", instr_out, prev_instr);
            compare_value("incr_pc", incr_pc, prev_incr);
            stall_cnt++;
         end else if (instr_out != NOP_WORD) begin
            compare_value("instr_out", instr_out, prog_data[idx]);
            compare_value("incr_pc", incr_pc, word_t'(prog_addr[idx] + PC_STEP));
            idx++;
         end
         prev_instr = instr_out;
         prev_incr  = incr_pc;
      end
      @(posedge clk);
      mem_stall <= 1'b0;
      assert (idx == STALL_WORDS) else begin
         $display("Only %0d of %0d words came out under random stalls", idx, STALL_WORDS);
         report_failure();
      end
      assert (stall_cnt > 0) else begin
         $display("The stall test never held the pipeline");
         report_failure();
      end
   endtask

   task automatic unaligned_redirect();
      clear_program();
      place_word(16'h0000, filler_word());
      place_word(16'h0002, filler_word());
      place_word(16'h0004, HALT_WORD);
      // Odd address 0x21 still reads word index 0x10
      place_word(16'h0020, filler_word());
      reset_and_load();
      expect_word(prog_data[0], prog_addr[0]);
      compare_value("unaligned_error_out", word_t'(unaligned_error_out), 16'h0000);
      send_redirect(16'h0021);
      expect_word(prog_data[3], 16'h0021);
      compare_value("unaligned_error_out", word_t'(unaligned_error_out), 16'h0001);
      @(negedge clk);
      compare_value("unaligned_error_out", word_t'(unaligned_error_out), 16'h0000);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst        = 1'b1;
      pc_src     = 1'b0;
      jump_pc    = '0;
      squash     = 1'b0;
      mem_stall  = 1'b0;
      dst1       = '0;
      valid1     = 1'b0;
      instr_in_x = NOP_WORD;
      load_we    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      void'($urandom(40));
      straight_line_fetch();
      raw_hazard_stall();
      jump_and_redirect();
      halt_and_dump();
      mem_stall_hold();
      unaligned_redirect();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* fetch_stage.f */
src/fetch_pkg.sv
src/fetch_pc.sv
src/imem_stall.sv
src/inst_decode.sv
src/raw_detector.sv
src/fetch_ctrl.sv
src/fetch_stage.sv
tb/fetch_stage_tb.sv
